/* hdl/mem_pkg.sv */
package mem_pkg;

    ////////////////////////////////////////
    // data path types
    ////////////////////////////////////////

    // fixed by the instruction set.
    localparam int word_w = 32;

    typedef logic [word_w-1:0] word_t;
    typedef logic [4:0]        reg_addr_t;

    // bit 3 is the lane at offset 0, big-endian.
    typedef logic [3:0]        byte_sel_t;

    ////////////////////////////////////////
    // memory opcodes
    ////////////////////////////////////////

    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LB,
        MEM_LBU,
        MEM_LH,
        MEM_LHU,
        MEM_LW,
        MEM_LWL,
        MEM_LWR,
        MEM_SB,
        MEM_SH,
        MEM_SW,
        MEM_SWL,
        MEM_SWR,
        MEM_LL,
        MEM_SC
    } mem_op_e;

endpackage

/* hdl/mem_request.sv */
module mem_request #(
    parameter int addr_w = 32
) (
    input  logic                clk,
    input  logic                rst_n,
    input  mem_pkg::mem_op_e    op,
    input  logic [addr_w-1:0]   addr,
    input  mem_pkg::word_t      reg2,
    output logic [addr_w-1:0]   mem_addr,
    output logic                mem_ce,
    output logic                mem_we,
    output mem_pkg::byte_sel_t  mem_sel,
    output mem_pkg::word_t      mem_wdata,
    output logic                sc_valid,
    output logic                sc_done
);

    logic [1:0]         offset;
    logic [4:0]         byte_shift;
    logic [addr_w-1:0]  word_addr;
    mem_pkg::byte_sel_t byte_lane;
    mem_pkg::byte_sel_t half_lanes;
    logic               half_ok;
    logic               link_bit;

    ////////////////////////////////////////
    // address decode
    ////////////////////////////////////////

    assign offset     = addr[1:0];
    assign byte_shift = {offset, 3'b000};
    assign word_addr  = {addr[addr_w-1:2], 2'b00};

    // one lane per byte offset.
    assign byte_lane  = 4'b1000 >> offset;

    // halfwords only at offset 0 or 2.
    assign half_ok    = ~offset[0];
    assign half_lanes = half_ok ? (offset[1] ? 4'b0011 : 4'b1100) : 4'b0000;

    // store-conditional succeeds only while linked.
    assign sc_valid = (op == mem_pkg::MEM_SC);
    assign sc_done  = sc_valid & link_bit;

    ////////////////////////////////////////
    // memory port
    ////////////////////////////////////////

    always_comb begin
        mem_addr  = addr;
        mem_ce    = 1'b0;
        mem_we    = 1'b0;
        mem_sel   = 4'b0000;
        mem_wdata = '0;
        case (op)
            mem_pkg::MEM_LB, mem_pkg::MEM_LBU: begin
                mem_ce  = 1'b1;
                mem_sel = byte_lane;
            end
            mem_pkg::MEM_LH, mem_pkg::MEM_LHU: begin
                mem_ce  = 1'b1;
                mem_sel = half_ok ? half_lanes : 4'b1111;
            end
            mem_pkg::MEM_LW, mem_pkg::MEM_LL: begin
                mem_ce  = 1'b1;
                mem_sel = 4'b1111;
            end
            mem_pkg::MEM_LWL, mem_pkg::MEM_LWR: begin
                mem_addr = word_addr;
                mem_ce   = 1'b1;
                mem_sel  = 4'b1111;
            end
            mem_pkg::MEM_SB: begin
                mem_ce    = 1'b1;
                mem_we    = 1'b1;
                mem_sel   = byte_lane;
                mem_wdata = {4{reg2[7:0]}};
            end
            mem_pkg::MEM_SH: begin
                mem_ce    = 1'b1;
                mem_we    = 1'b1;
                mem_sel   = half_lanes;
                mem_wdata = {2{reg2[15:0]}};
            end
            mem_pkg::MEM_SW: begin
                mem_ce    = 1'b1;
                mem_we    = 1'b1;
                mem_sel   = 4'b1111;
                mem_wdata = reg2;
            end
            // upper bytes of reg2 go from the offset down.
            mem_pkg::MEM_SWL: begin
                mem_addr  = word_addr;
                mem_ce    = 1'b1;
                mem_we    = 1'b1;
                mem_sel   = 4'b1111 >> offset;
                mem_wdata = reg2 >> byte_shift;
            end
            // lower bytes of reg2 fill up to the offset.
            mem_pkg::MEM_SWR: begin
                mem_addr  = word_addr;
                mem_ce    = 1'b1;
                mem_we    = 1'b1;
                mem_sel   = 4'b1111 << (2'd3 - offset);
                mem_wdata = reg2 << (5'd24 - byte_shift);
            end
            mem_pkg::MEM_SC: begin
                if (link_bit) begin
                    mem_ce    = 1'b1;
                    mem_we    = 1'b1;
                    mem_sel   = 4'b1111;
                    mem_wdata = reg2;
                end
            end
            default: begin
            end
        endcase
        // no access while in reset.
        if (!rst_n) begin
            mem_ce = 1'b0;
            mem_we = 1'b0;
        end
    end

    ////////////////////////////////////////
    // link bit
    ////////////////////////////////////////

    // updates on the commit edge.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            link_bit <= 1'b0;
        end else if (op == mem_pkg::MEM_LL) begin
            link_bit <= 1'b1;
        end else if (sc_done) begin
            link_bit <= 1'b0;
        end
    end

endmodule

/* hdl/load_extract.sv */
module load_extract (
    input  mem_pkg::mem_op_e  op,
    input  logic [1:0]        offset,
    input  mem_pkg::word_t    reg2,
    input  mem_pkg::word_t    mem_rdata,
    output logic              load_valid,
    output mem_pkg::word_t    load_data
);

    logic [4:0]  byte_base;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    logic        half_ok;

    // offset 0 is the top byte of the word.
    assign byte_base = {~offset, 3'b000};
    assign sel_byte  = mem_rdata[byte_base +: 8];
    assign sel_half  = offset[1] ? mem_rdata[15:0] : mem_rdata[31:16];
    assign half_ok   = ~offset[0];

    always_comb begin
        load_valid = 1'b1;
        load_data  = '0;
        case (op)
            mem_pkg::MEM_LB: begin
                load_data = {{24{sel_byte[7]}}, sel_byte};
            end
            mem_pkg::MEM_LBU: begin
                load_data = {24'b0, sel_byte};
            end
            // misaligned halfwords read as zero.
            mem_pkg::MEM_LH: begin
                if (half_ok) begin
                    load_data = {{16{sel_half[15]}}, sel_half};
                end
            end
            mem_pkg::MEM_LHU: begin
                if (half_ok) begin
                    load_data = {16'b0, sel_half};
                end
            end
            mem_pkg::MEM_LW, mem_pkg::MEM_LL: begin
                load_data = mem_rdata;
            end
            mem_pkg::MEM_LWL: begin
                case (offset)
                    2'd0: load_data = mem_rdata;
                    2'd1: load_data = {mem_rdata[23:0], reg2[7:0]};
                    2'd2: load_data = {mem_rdata[15:0], reg2[15:0]};
                    default: load_data = {mem_rdata[7:0], reg2[23:0]};
                endcase
            end
            mem_pkg::MEM_LWR: begin
                case (offset)
                    2'd0: load_data = {reg2[31:8], mem_rdata[31:24]};
                    2'd1: load_data = {reg2[31:16], mem_rdata[31:16]};
                    2'd2: load_data = {reg2[31:24], mem_rdata[31:8]};
                    default: load_data = mem_rdata;
                endcase
            end
            default: begin
                load_valid = 1'b0;
            end
        endcase
    end

endmodule

/* hdl/wb_reg.sv */
module wb_reg (
    input  logic                clk,
    input  logic                rst_n,
    input  mem_pkg::reg_addr_t  wr_addr,
    input  logic                wr_en,
    input  mem_pkg::word_t      alu_data,
    input  logic                load_valid,
    input  mem_pkg::word_t      load_data,
    input  logic                sc_valid,
    input  logic                sc_done,
    output mem_pkg::reg_addr_t  wb_addr,
    output logic                wb_en,
    output mem_pkg::word_t      wb_data
);

    mem_pkg::word_t wb_value;

    ////////////////////////////////////////
    // writeback select
    ////////////////////////////////////////

    // loads first, then the sc flag, then alu.
    always_comb begin
        if (load_valid) begin
            wb_value = load_data;
        end else if (sc_valid) begin
            wb_value = {{(mem_pkg::word_w-1){1'b0}}, sc_done};
        end else begin
            wb_value = alu_data;
        end
    end

    ////////////////////////////////////////
    // writeback register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_addr <= '0;
            wb_en   <= 1'b0;
            wb_data <= '0;
        end else begin
            wb_addr <= wr_addr;
            wb_en   <= wr_en;
            wb_data <= wb_value;
        end
    end

endmodule

/* hdl/mem_stage.sv */
module mem_stage #(
    parameter int addr_w = 32
) (
    input  logic                clk,
    input  logic                rst_n,
    input  mem_pkg::mem_op_e    op,
    input  logic [addr_w-1:0]   addr,
    input  mem_pkg::word_t      reg2,
    input  mem_pkg::word_t      alu_data,
    input  mem_pkg::reg_addr_t  wr_addr,
    input  logic                wr_en,
    input  mem_pkg::word_t      mem_rdata,
    output logic [addr_w-1:0]   mem_addr,
    output logic                mem_ce,
    output logic                mem_we,
    output mem_pkg::byte_sel_t  mem_sel,
    output mem_pkg::word_t      mem_wdata,
    output mem_pkg::reg_addr_t  wb_addr,
    output logic                wb_en,
    output mem_pkg::word_t      wb_data
);

    logic           sc_valid;
    logic           sc_done;
    logic           load_valid;
    mem_pkg::word_t load_data;

    mem_request #(
        .addr_w    (addr_w)
    ) u_mem_request (
        .clk       (clk),
        .rst_n     (rst_n),
        .op        (op),
        .addr      (addr),
        .reg2      (reg2),
        .mem_addr  (mem_addr),
        .mem_ce    (mem_ce),
        .mem_we    (mem_we),
        .mem_sel   (mem_sel),
        .mem_wdata (mem_wdata),
        .sc_valid  (sc_valid),
        .sc_done   (sc_done)
    );

    // read data is back in the same cycle.
    load_extract u_load_extract (
        .op         (op),
        .offset     (addr[1:0]),
        .reg2       (reg2),
        .mem_rdata  (mem_rdata),
        .load_valid (load_valid),
        .load_data  (load_data)
    );

    wb_reg u_wb_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_addr    (wr_addr),
        .wr_en      (wr_en),
        .alu_data   (alu_data),
        .load_valid (load_valid),
        .load_data  (load_data),
        .sc_valid   (sc_valid),
        .sc_done    (sc_done),
        .wb_addr    (wb_addr),
        .wb_en      (wb_en),
        .wb_data    (wb_data)
    );

endmodule

/* testbench/mem_stage_props.sv */
module mem_stage_props #(
    parameter int addr_w = 32
) (
    input logic               clk,
    input logic               rst_n,
    input mem_pkg::mem_op_e   op,
    input logic [addr_w-1:0]  addr,
    input logic               mem_ce,
    input logic               mem_we,
    input mem_pkg::byte_sel_t mem_sel,
    input logic               wb_en
);
    timeunit 1ns;
    timeprecision 1ps;

    we_needs_ce: assert property (@(posedge clk) mem_we |-> mem_ce)
        else $error("mem_we is set while mem_ce is clear");

    // a misaligned sh is the one enabled access with no lanes.
    sel_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ce && !(op == mem_pkg::MEM_SH && addr[0]) |-> mem_sel != 4'b0000)
        else $error("mem_sel is zero on an enabled access");

    wb_clear: assert property (@(posedge clk) !rst_n |=> !wb_en)
        else $error("wb_en is set in the cycle after reset");

endmodule

/* testbench/tb_mem_stage.sv */
module tb_mem_stage;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int addr_w = 32;

    logic               clk;
    logic               rst_n;
    mem_pkg::mem_op_e   op;
    logic [addr_w-1:0]  addr;
    mem_pkg::word_t     reg2;
    mem_pkg::word_t     alu_data;
    mem_pkg::reg_addr_t wr_addr;
    logic               wr_en;
    mem_pkg::word_t     mem_rdata;
    logic [addr_w-1:0]  mem_addr;
    logic               mem_ce;
    logic               mem_we;
    mem_pkg::byte_sel_t mem_sel;
    mem_pkg::word_t     mem_wdata;
    mem_pkg::reg_addr_t wb_addr;
    logic               wb_en;
    mem_pkg::word_t     wb_data;
    mem_pkg::word_t     mem [0:15];

    mem_stage #(.addr_w(addr_w)) UUT (.*);

    bind mem_stage mem_stage_props #(.addr_w(addr_w)) u_props (
        .clk(clk), .rst_n(rst_n), .op(op), .addr(addr),
        .mem_ce(mem_ce), .mem_we(mem_we), .mem_sel(mem_sel), .wb_en(wb_en)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////
    // memory model
    ////////////////////////////////////////

    assign mem_rdata = mem[mem_addr[5:2]];

    // lane 3 is bits 31:24.
    always @(posedge clk) begin
        if (mem_ce && mem_we) begin
            for (int i = 0; i < 4; i++) begin
                if (mem_sel[i]) begin
                    mem[mem_addr[5:2]][i*8 +: 8] <= mem_wdata[i*8 +: 8];
                end
            end
        end
    end

    function automatic mem_pkg::word_t fill_word(input int idx);
        return {16'hC0DE, 8'(idx), 8'(idx * 4)};
    endfunction

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic check(input string name, input mem_pkg::word_t got,
                         input mem_pkg::word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Test failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // drive at a falling edge, return at the next one.
    task automatic run_op(input mem_pkg::mem_op_e o, input logic [31:0] a,
                          input mem_pkg::word_t r);
        op       = o;
        addr     = a;
        reg2     = r;
        alu_data = 32'hA5A5A5A5;
        wr_addr  = a[4:0];
        wr_en    = 1'b1;
        @(negedge clk);
    endtask

    task automatic load_check(input mem_pkg::mem_op_e o, input logic [31:0] a,
                              input mem_pkg::word_t r, input mem_pkg::word_t exp);
        run_op(o, a, r);
        check("wb_data", wb_data, exp);
        check("wb_addr", wb_addr, a[4:0]);
        check("wb_en", wb_en, 1);
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic reset_test();
        @(negedge clk);
        check("mem_ce", mem_ce, 0);
        check("mem_we", mem_we, 0);
        // a load-linked held in reset leaves the link bit clear.
        op = mem_pkg::MEM_LL;
        @(negedge clk);
        check("wb_en", wb_en, 0);
        check("wb_addr", wb_addr, 0);
        check("wb_data", wb_data, 0);
        check("mem_ce", mem_ce, 0);
        check("mem_we", mem_we, 0);
        @(negedge clk);
        rst_n    = 1'b1;
        op       = mem_pkg::MEM_NONE;
        alu_data = '0;
        wr_en    = 1'b0;
        @(negedge clk);
        check("wb_en", wb_en, 0);
        check("wb_data", wb_data, 0);
    endtask

    task automatic lane_store_test();
        run_op(mem_pkg::MEM_SW, 32'h10, 32'h11223344);
        // stores write back the alu result.
        check("wb_data", wb_data, 32'hA5A5A5A5);
        run_op(mem_pkg::MEM_SB, 32'h11, 32'h000000AA);
        run_op(mem_pkg::MEM_SH, 32'h12, 32'h0000BBCC);
        load_check(mem_pkg::MEM_LW, 32'h10, 0, 32'h11AABBCC);
        // misaligned halfword store.
        run_op(mem_pkg::MEM_SH, 32'h11, 32'h0000FFFF);
        load_check(mem_pkg::MEM_LW, 32'h10, 0, 32'h11AABBCC);
    endtask

    task automatic extend_test();
        mem_pkg::word_t     lb_exp [4];
        mem_pkg::byte_sel_t lb_sel [4];
        lb_exp = '{32'hFFFFFF80, 32'h0000007F, 32'hFFFFFFF0, 32'h00000012};
        lb_sel = '{4'b1000, 4'b0100, 4'b0010, 4'b0001};
        run_op(mem_pkg::MEM_SW, 32'h20, 32'h807FF012);
        for (int k = 0; k < 4; k++) begin
            load_check(mem_pkg::MEM_LB, 32'h20 + k, 0, lb_exp[k]);
            check("mem_sel", mem_sel, lb_sel[k]);
            check("mem_addr", mem_addr, 32'h20 + k);
            load_check(mem_pkg::MEM_LBU, 32'h20 + k, 0, lb_exp[k] & 32'hFF);
        end
        load_check(mem_pkg::MEM_LH, 32'h20, 0, 32'hFFFF807F);
        check("mem_sel", mem_sel, 4'b1100);
        load_check(mem_pkg::MEM_LHU, 32'h20, 0, 32'h0000807F);
        load_check(mem_pkg::MEM_LH, 32'h22, 0, 32'hFFFFF012);
        check("mem_sel", mem_sel, 4'b0011);
        load_check(mem_pkg::MEM_LHU, 32'h22, 0, 32'h0000F012);
        load_check(mem_pkg::MEM_LH, 32'h21, 0, 32'h00000000);
        check("mem_sel", mem_sel, 4'b1111);
    endtask

    task automatic merge_test();
        mem_pkg::word_t lwl_exp [4];
        mem_pkg::word_t lwr_exp [4];
        mem_pkg::word_t swl_exp [4];
        mem_pkg::word_t swr_exp [4];
        lwl_exp = '{32'h01234567, 32'h234567D4, 32'h4567C3D4, 32'h67B2C3D4};
        lwr_exp = '{32'hA1B2C301, 32'hA1B20123, 32'hA1012345, 32'h01234567};
        swl_exp = '{32'hA1B2C3D4, 32'h01A1B2C3, 32'h0123A1B2, 32'h012345A1};
        swr_exp = '{32'hD4234567, 32'hC3D44567, 32'hB2C3D467, 32'hA1B2C3D4};
        run_op(mem_pkg::MEM_SW, 32'h30, 32'h01234567);
        for (int k = 0; k < 4; k++) begin
            load_check(mem_pkg::MEM_LWL, 32'h30 + k, 32'hA1B2C3D4, lwl_exp[k]);
            check("mem_addr", mem_addr, 32'h30);
            load_check(mem_pkg::MEM_LWR, 32'h30 + k, 32'hA1B2C3D4, lwr_exp[k]);
            check("mem_addr", mem_addr, 32'h30);
        end
        for (int k = 0; k < 4; k++) begin
            run_op(mem_pkg::MEM_SW, 32'h34, 32'h01234567);
            run_op(mem_pkg::MEM_SWL, 32'h34 + k, 32'hA1B2C3D4);
            check("mem_addr", mem_addr, 32'h34);
            load_check(mem_pkg::MEM_LW, 32'h34, 0, swl_exp[k]);
            run_op(mem_pkg::MEM_SW, 32'h34, 32'h01234567);
            run_op(mem_pkg::MEM_SWR, 32'h34 + k, 32'hA1B2C3D4);
            check("mem_addr", mem_addr, 32'h34);
            load_check(mem_pkg::MEM_LW, 32'h34, 0, swr_exp[k]);
        end
    endtask

    task automatic link_test();
        // no ll has been issued since reset.
        load_check(mem_pkg::MEM_SC, 32'h38, 32'h55555555, 0);
        check("mem_ce", mem_ce, 0);
        load_check(mem_pkg::MEM_LW, 32'h38, 0, fill_word(14));
        load_check(mem_pkg::MEM_LL, 32'h38, 0, fill_word(14));
        load_check(mem_pkg::MEM_SC, 32'h38, 32'h12345678, 1);
        load_check(mem_pkg::MEM_LW, 32'h38, 0, 32'h12345678);
        load_check(mem_pkg::MEM_SC, 32'h38, 32'h0BADF00D, 0);
        load_check(mem_pkg::MEM_LW, 32'h38, 0, 32'h12345678);
    endtask

    initial begin
        rst_n     = 1'b0;
        // a store held in reset must not reach memory.
        op        = mem_pkg::MEM_SW;
        addr      = 32'h38;
        reg2      = 32'h77777777;
        alu_data  = 32'h5A5A5A5A;
        wr_addr   = 5'd17;
        wr_en     = 1'b1;
        for (int i = 0; i < 16; i++) begin
            mem[i] = fill_word(i);
        end
        reset_test();
        lane_store_test();
        extend_test();
        merge_test();
        link_test();
        $display("Test completed successfully");
        $finish;
    end

    initial begin
        repeat (500) @(posedge clk);
        $display("timeout: the tests did not finish within 500 clock cycles");
        $display("Test failed");
        $fatal(1, "timeout");
    end

endmodule

/* verilog.f */
hdl/mem_pkg.sv
hdl/mem_request.sv
hdl/load_extract.sv
hdl/wb_reg.sv
hdl/mem_stage.sv
testbench/mem_stage_props.sv
testbench/tb_mem_stage.sv

/* Bender.yml */
package:
  name: mem_stage

sources:
  - hdl/mem_pkg.sv
  - hdl/mem_request.sv
  - hdl/load_extract.sv
  - hdl/wb_reg.sv
  - hdl/mem_stage.sv
  - target: test
    files:
      - testbench/mem_stage_props.sv
      - testbench/tb_mem_stage.sv
